// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  ////////////////////////////////////////////////////////////
  // Primary opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [5:0] OP_RTYPE = 6'h00;  // Decoded further by funct
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_ANDI  = 6'h0c;  // Zero-extended immediates
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type function codes
  localparam logic [5:0] FN_SLL  = 6'h00;  // Shift by shamt
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  localparam logic [4:0] REG_RA = 5'd31;  // Link register for jal

  ////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;  // Sign or zero extended per opcode
  } i_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;  // Word index within 256 MB region
  } j_fields_t;

  // Same 32 bits, three decodings
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    j_fields_t j;
  } instr_u;

endpackage

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////////////////////////
  // Memories and load port
  ////////////////////////////////////////////////////////////
  localparam int MEM_WORDS = 1024;  // Depth of imem and dmem each
  localparam int MEM_AW    = 10;    // Word address bits
  localparam int UPG_AW    = 15;    // Top bit picks dmem over imem

  // Memory-mapped I/O
  localparam logic [31:0] IO_LED_ADDR    = 32'hFFFF_FC60;
  localparam logic [31:0] IO_SWITCH_ADDR = 32'hFFFF_FC70;
  localparam int          IO_W           = 24;  // LED and switch width

  ////////////////////////////////////////////////////////////
  // ALU operation codes
  ////////////////////////////////////////////////////////////
  localparam logic [3:0] ALU_ADD = 4'd0;   // addu, addiu, lw, sw
  localparam logic [3:0] ALU_SUB = 4'd1;   // subu and branch compare
  localparam logic [3:0] ALU_AND = 4'd2;
  localparam logic [3:0] ALU_OR  = 4'd3;
  localparam logic [3:0] ALU_XOR = 4'd4;
  localparam logic [3:0] ALU_NOR = 4'd5;
  localparam logic [3:0] ALU_SLT = 4'd6;   // Signed compare
  localparam logic [3:0] ALU_SLL = 4'd7;
  localparam logic [3:0] ALU_SRL = 4'd8;
  localparam logic [3:0] ALU_SRA = 4'd9;   // Arithmetic, keeps sign
  localparam logic [3:0] ALU_LUI = 4'd10;  // Immediate to upper half

endpackage

`default_nettype wire

// ==== logic/inst_fetch.sv ====
`default_nettype none

module inst_fetch (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         run_i,
  input  wire                         branch_i,         // beq
  input  wire                         nbranch_i,        // bne
  input  wire                         jmp_i,
  input  wire                         jal_i,
  input  wire                         jr_i,
  input  wire                         zero_i,
  input  wire  [31:0]                 branch_target_i,
  input  wire  [31:0]                 rs_data_i,        // jr target
  input  wire                         upg_wen_i,
  input  wire  [core_pkg::UPG_AW-1:0] upg_adr_i,
  input  wire  [31:0]                 upg_dat_i,
  output isa_pkg::instr_u             instr_o,
  output logic [31:0]                 pc_plus4_o
);
  import core_pkg::*;

  logic [31:0] imem [MEM_WORDS];  // Program ROM, filled by load port
  logic [31:0] pc_q;
  logic [31:0] pc_next;
  logic        br_taken;

  // Unwritten words decode as sll $0,$0,0
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = '0;
  end

  // Load port, imem half only
  always_ff @(posedge clk) begin
    if (!run_i && upg_wen_i && !upg_adr_i[UPG_AW-1]) begin
      imem[upg_adr_i[MEM_AW-1:0]] <= upg_dat_i;
    end
  end

  assign instr_o    = imem[pc_q[MEM_AW+1:2]];  // Wraps inside imem
  assign pc_plus4_o = pc_q + 32'd4;
  assign br_taken   = (branch_i && zero_i) || (nbranch_i && !zero_i);

  // Next PC priority
  always_comb begin
    if (jr_i) begin
      pc_next = rs_data_i;
    end else if (jmp_i || jal_i) begin
      pc_next = {pc_plus4_o[31:28], instr_o.j.target, 2'b00};  // Region of PC+4
    end else if (br_taken) begin
      pc_next = branch_target_i;
    end else begin
      pc_next = pc_plus4_o;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (run_i) begin  // Held through load mode
      pc_q <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== logic/main_control.sv ====
`default_nettype none

module main_control (
  input  wire isa_pkg::instr_u instr_i,
  output logic                 reg_dst_o,    // Write rd instead of rt
  output logic                 alu_src_o,    // Operand B from immediate
  output logic                 mem_to_reg_o,
  output logic                 reg_write_o,
  output logic                 mem_read_o,
  output logic                 mem_write_o,
  output logic                 branch_o,
  output logic                 nbranch_o,
  output logic                 jmp_o,
  output logic                 jal_o,
  output logic                 jr_o,
  output logic                 zero_ext_o,
  output logic                 shift_o,
  output logic [3:0]           alu_op_o
);
  import isa_pkg::*;
  import core_pkg::*;

  always_comb begin
    // Unknown encodings fall through as nops
    reg_dst_o    = 1'b0;
    alu_src_o    = 1'b0;
    mem_to_reg_o = 1'b0;
    reg_write_o  = 1'b0;
    mem_read_o   = 1'b0;
    mem_write_o  = 1'b0;
    branch_o     = 1'b0;
    nbranch_o    = 1'b0;
    jmp_o        = 1'b0;
    jal_o        = 1'b0;
    jr_o         = 1'b0;
    zero_ext_o   = 1'b0;
    shift_o      = 1'b0;
    alu_op_o     = ALU_ADD;
    case (instr_i.r.opcode)
      OP_RTYPE: begin
        reg_dst_o   = 1'b1;
        reg_write_o = 1'b1;
        case (instr_i.r.funct)
          FN_ADDU: alu_op_o = ALU_ADD;
          FN_SUBU: alu_op_o = ALU_SUB;
          FN_AND:  alu_op_o = ALU_AND;
          FN_OR:   alu_op_o = ALU_OR;
          FN_XOR:  alu_op_o = ALU_XOR;
          FN_NOR:  alu_op_o = ALU_NOR;
          FN_SLT:  alu_op_o = ALU_SLT;
          FN_SLL:  begin alu_op_o = ALU_SLL; shift_o = 1'b1; end
          FN_SRL:  begin alu_op_o = ALU_SRL; shift_o = 1'b1; end
          FN_SRA:  begin alu_op_o = ALU_SRA; shift_o = 1'b1; end
          FN_JR:   begin jr_o = 1'b1; reg_write_o = 1'b0; end  // No link write
          default: reg_write_o = 1'b0;
        endcase
      end
      OP_ADDIU: begin alu_src_o = 1'b1; reg_write_o = 1'b1; end
      OP_SLTI:  begin alu_src_o = 1'b1; reg_write_o = 1'b1; alu_op_o = ALU_SLT; end
      OP_ANDI:  begin alu_src_o = 1'b1; reg_write_o = 1'b1; zero_ext_o = 1'b1; alu_op_o = ALU_AND; end
      OP_ORI:   begin alu_src_o = 1'b1; reg_write_o = 1'b1; zero_ext_o = 1'b1; alu_op_o = ALU_OR; end
      OP_XORI:  begin alu_src_o = 1'b1; reg_write_o = 1'b1; zero_ext_o = 1'b1; alu_op_o = ALU_XOR; end
      OP_LUI:   begin alu_src_o = 1'b1; reg_write_o = 1'b1; alu_op_o = ALU_LUI; end
      OP_LW:    begin alu_src_o = 1'b1; reg_write_o = 1'b1; mem_read_o = 1'b1; mem_to_reg_o = 1'b1; end
      OP_SW:    begin alu_src_o = 1'b1; mem_write_o = 1'b1; end  // Address is rs + imm
      OP_BEQ:   begin branch_o = 1'b1; alu_op_o = ALU_SUB; end   // Zero flag decides
      OP_BNE:   begin nbranch_o = 1'b1; alu_op_o = ALU_SUB; end
      OP_J:     jmp_o = 1'b1;
      OP_JAL:   begin jal_o = 1'b1; reg_write_o = 1'b1; end
      default:  ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/reg_decode.sv ====
`default_nettype none

module reg_decode (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  run_i,
  input  wire isa_pkg::instr_u instr_i,
  input  wire                  reg_write_i,
  input  wire                  reg_dst_i,
  input  wire                  jal_i,
  input  wire                  mem_to_reg_i,
  input  wire                  zero_ext_i,
  input  wire  [31:0]          alu_result_i,
  input  wire  [31:0]          mem_data_i,    // RAM or I/O read
  input  wire  [31:0]          pc_plus4_i,    // Link value
  output logic [31:0]          rs_data_o,
  output logic [31:0]          rt_data_o,
  output logic [31:0]          imm_ext_o
);
  import isa_pkg::*;

  logic [31:0] regs [32];
  logic [4:0]  waddr;
  logic [31:0] wdata;

  // Read ports, $0 hardwired
  assign rs_data_o = (instr_i.r.rs == 5'd0) ? '0 : regs[instr_i.r.rs];
  assign rt_data_o = (instr_i.r.rt == 5'd0) ? '0 : regs[instr_i.r.rt];

  // Logical immediates zero extend, all others sign extend
  assign imm_ext_o = zero_ext_i ? {16'h0000, instr_i.i.imm}
                                : {{16{instr_i.i.imm[15]}}, instr_i.i.imm};

  ////////////////////////////////////////////////////////////
  // Write-back select
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (jal_i) begin
      waddr = REG_RA;
    end else if (reg_dst_i) begin
      waddr = instr_i.r.rd;  // R-type destination
    end else begin
      waddr = instr_i.i.rt;  // I-type destination
    end
  end

  always_comb begin
    if (jal_i) begin
      wdata = pc_plus4_i;  // Return address
    end else if (mem_to_reg_i) begin
      wdata = mem_data_i;
    end else begin
      wdata = alu_result_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (run_i && reg_write_i && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;  // Writes to $0 dropped
    end
  end

endmodule

`default_nettype wire

// ==== logic/alu_exec.sv ====
`default_nettype none

module alu_exec (
  input  wire  [31:0]          rs_data_i,
  input  wire  [31:0]          rt_data_i,
  input  wire  [31:0]          imm_ext_i,
  input  wire isa_pkg::instr_u instr_i,
  input  wire                  alu_src_i,
  input  wire                  shift_i,
  input  wire  [3:0]           alu_op_i,
  input  wire  [31:0]          pc_plus4_i,
  output logic [31:0]          alu_result_o,
  output logic                 zero_o,
  output logic [31:0]          branch_target_o
);
  import core_pkg::*;

  logic [31:0] op_b;
  logic [4:0]  sh_amt;

  assign op_b = alu_src_i ? imm_ext_i : rt_data_i;  // Immediate or rt

  // Constant shifts take shamt, otherwise rs low bits
  assign sh_amt = shift_i ? instr_i.r.shamt : rs_data_i[4:0];

  ////////////////////////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (alu_op_i)
      ALU_ADD: alu_result_o = rs_data_i + op_b;
      ALU_SUB: alu_result_o = rs_data_i - op_b;
      ALU_AND: alu_result_o = rs_data_i & op_b;
      ALU_OR:  alu_result_o = rs_data_i | op_b;
      ALU_XOR: alu_result_o = rs_data_i ^ op_b;
      ALU_NOR: alu_result_o = ~(rs_data_i | op_b);
      ALU_SLT: begin
        alu_result_o = {31'd0, $signed(rs_data_i) < $signed(op_b)};  // 1 or 0
      end
      ALU_SLL: alu_result_o = op_b << sh_amt;   // Shifts act on rt
      ALU_SRL: alu_result_o = op_b >> sh_amt;
      ALU_SRA: alu_result_o = $signed(op_b) >>> sh_amt;
      ALU_LUI: alu_result_o = {op_b[15:0], 16'h0000};
      default: alu_result_o = '0;
    endcase
  end

  // beq and bne compare through ALU_SUB
  assign zero_o = (alu_result_o == 32'd0);

  // Branch offset is in words
  assign branch_target_o = pc_plus4_i + {imm_ext_i[29:0], 2'b00};

endmodule

`default_nettype wire

// ==== logic/dmem_io.sv ====
`default_nettype none

module dmem_io (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         run_i,
  input  wire                         mem_read_i,
  input  wire                         mem_write_i,
  input  wire  [31:0]                 addr_i,       // Byte address from ALU
  input  wire  [31:0]                 wdata_i,
  input  wire  [core_pkg::IO_W-1:0]   switch_i,
  input  wire                         upg_wen_i,
  input  wire  [core_pkg::UPG_AW-1:0] upg_adr_i,
  input  wire  [31:0]                 upg_dat_i,
  output logic [31:0]                 rdata_o,
  output logic [core_pkg::IO_W-1:0]   led_o
);
  import core_pkg::*;

  logic [31:0]       ram [MEM_WORDS];
  logic [MEM_AW-1:0] ram_idx;
  logic              is_led;
  logic              is_sw;

  assign ram_idx = addr_i[MEM_AW+1:2];  // Word index, wraps
  assign is_led  = (addr_i == IO_LED_ADDR);
  assign is_sw   = (addr_i == IO_SWITCH_ADDR);

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) ram[i] = '0;
  end

  // RAM port shared by loader and core
  always_ff @(posedge clk) begin
    if (!run_i && upg_wen_i && upg_adr_i[UPG_AW-1]) begin
      ram[upg_adr_i[MEM_AW-1:0]] <= upg_dat_i;  // Load port, dmem half
    end else if (run_i && mem_write_i && !is_led && !is_sw) begin
      ram[ram_idx] <= wdata_i;
    end
  end

  // LED register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      led_o <= '0;
    end else if (run_i && mem_write_i && is_led) begin
      led_o <= wdata_i[IO_W-1:0];  // Low bits only
    end
  end

  // Read mux, zero when no lw
  always_comb begin
    if (!mem_read_i) begin
      rdata_o = '0;
    end else if (is_sw) begin
      rdata_o = {{(32-IO_W){1'b0}}, switch_i};  // Sampled this cycle
    end else if (is_led) begin
      rdata_o = {{(32-IO_W){1'b0}}, led_o};
    end else begin
      rdata_o = ram[ram_idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`default_nettype none

module cpu_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire  [core_pkg::IO_W-1:0]   switch_i,
  output logic [core_pkg::IO_W-1:0]   led_o,
  output logic [31:0]                 debug_o,     // Current ALU result
  input  wire                         upg_wen_i,
  input  wire  [core_pkg::UPG_AW-1:0] upg_adr_i,
  input  wire  [31:0]                 upg_dat_i,
  input  wire                         upg_done_i   // Ends load mode
);
  import isa_pkg::*;

  logic        run_q;
  instr_u      instr;
  logic [31:0] pc_plus4;
  logic        reg_dst, alu_src, mem_to_reg, reg_write;
  logic        mem_read, mem_write;
  logic        branch, nbranch, jmp, jal, jr;
  logic        zero_ext, shift;
  logic [3:0]  alu_op;
  logic [31:0] rs_data, rt_data, imm_ext;
  logic [31:0] alu_result;
  logic        zero;
  logic [31:0] branch_target;
  logic [31:0] mem_rdata;

  // Load mode after reset, run after done pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else if (upg_done_i) begin
      run_q <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Single-cycle datapath
  ////////////////////////////////////////////////////////////
  inst_fetch u_fetch (
    .clk, .rst_n, .run_i(run_q),
    .branch_i(branch), .nbranch_i(nbranch), .jmp_i(jmp), .jal_i(jal), .jr_i(jr),
    .zero_i(zero), .branch_target_i(branch_target), .rs_data_i(rs_data),
    .upg_wen_i, .upg_adr_i, .upg_dat_i,
    .instr_o(instr), .pc_plus4_o(pc_plus4)
  );

  main_control u_ctrl (
    .instr_i(instr),
    .reg_dst_o(reg_dst), .alu_src_o(alu_src), .mem_to_reg_o(mem_to_reg),
    .reg_write_o(reg_write), .mem_read_o(mem_read), .mem_write_o(mem_write),
    .branch_o(branch), .nbranch_o(nbranch), .jmp_o(jmp), .jal_o(jal), .jr_o(jr),
    .zero_ext_o(zero_ext), .shift_o(shift), .alu_op_o(alu_op)
  );

  reg_decode u_dec (
    .clk, .rst_n, .run_i(run_q), .instr_i(instr),
    .reg_write_i(reg_write), .reg_dst_i(reg_dst), .jal_i(jal),
    .mem_to_reg_i(mem_to_reg), .zero_ext_i(zero_ext),
    .alu_result_i(alu_result), .mem_data_i(mem_rdata), .pc_plus4_i(pc_plus4),
    .rs_data_o(rs_data), .rt_data_o(rt_data), .imm_ext_o(imm_ext)
  );

  alu_exec u_exe (
    .rs_data_i(rs_data), .rt_data_i(rt_data), .imm_ext_i(imm_ext), .instr_i(instr),
    .alu_src_i(alu_src), .shift_i(shift), .alu_op_i(alu_op), .pc_plus4_i(pc_plus4),
    .alu_result_o(alu_result), .zero_o(zero), .branch_target_o(branch_target)
  );

  dmem_io u_mem (
    .clk, .rst_n, .run_i(run_q),
    .mem_read_i(mem_read), .mem_write_i(mem_write),
    .addr_i(alu_result), .wdata_i(rt_data), .switch_i,
    .upg_wen_i, .upg_adr_i, .upg_dat_i,
    .rdata_o(mem_rdata), .led_o
  );

  assign debug_o = alu_result;  // Observed before the edge

endmodule

`default_nettype wire

// ==== sim/tb_cpu_top.sv ====
`default_nettype none

module tb_cpu_top;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int PROG_LEN   = 96;
  localparam int SUB_IDX    = 93;    // Shared subroutine, entered only by jal
  localparam int DATA_LEN   = 64;
  localparam int MAX_CYCLES = 1000;  // Reset, 160 load, 400 run, plus margin

  logic              clk = 1'b0;
  logic              rst_n;
  logic [IO_W-1:0]   sw_in;
  logic [IO_W-1:0]   led;
  logic [31:0]       debug;
  logic              upg_wen;
  logic [UPG_AW-1:0] upg_adr;
  logic [31:0]       upg_dat;
  logic              upg_done;
  int                cycles = 0;
  int unsigned       seed = 38;

  // Reference ISA state
  logic [31:0]       imem_img [MEM_WORDS];  // Program image, also the model's imem
  logic [31:0]       m_dmem   [MEM_WORDS];  // Survives reset like the RAM
  logic [31:0]       m_regs   [32];
  logic [31:0]       m_pc;
  logic [IO_W-1:0]   m_led;

  cpu_top dut_i (
    .clk, .rst_n, .switch_i(sw_in), .led_o(led), .debug_o(debug),
    .upg_wen_i(upg_wen), .upg_adr_i(upg_adr), .upg_dat_i(upg_dat), .upg_done_i(upg_done)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      $display("STATUS: FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Program generator
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] alu_rtype(input int kind);
    logic [5:0] fn;
    if (kind < 5) begin
      case ($urandom % 7)
        0:       fn = FN_ADDU;
        1:       fn = FN_SUBU;
        2:       fn = FN_AND;
        3:       fn = FN_OR;
        4:       fn = FN_XOR;
        5:       fn = FN_NOR;
        default: fn = FN_SLT;
      endcase
      return {OP_RTYPE, 5'($urandom), 5'($urandom), 5'($urandom % 31), 5'd0, fn};
    end
    case ($urandom % 3)
      0:       fn = FN_SLL;
      1:       fn = FN_SRL;
      default: fn = FN_SRA;
    endcase
    return {OP_RTYPE, 5'd0, 5'($urandom), 5'($urandom % 31), 5'($urandom), fn};  // $31 kept for jal
  endfunction

  // RAM word offset, or the low half of an I/O address
  function automatic logic [15:0] mem_offset();
    int pick;
    pick = $urandom % 8;
    if (pick == 0) return IO_SWITCH_ADDR[15:0];  // Sign extends into the I/O page
    if (pick == 1) return IO_LED_ADDR[15:0];
    return 16'(($urandom % DATA_LEN) * 4);
  endfunction

  task automatic gen_program;
    logic [5:0] op;
    int         kind;
    int         tgt;
    for (int i = 0; i < SUB_IDX - 1; i++) begin
      kind = (i == 0) ? 7 : $urandom % 16;           // First word has an ALU result
      tgt  = i + 1 + $urandom % (SUB_IDX - 1 - i);  // Forward only, at most the j 0
      case (kind)
        0, 1, 2, 3, 4, 5, 6: imem_img[i] = alu_rtype(kind);
        7, 8, 9, 10: begin
          case ($urandom % 6)
            0:       op = OP_ADDIU;
            1:       op = OP_SLTI;
            2:       op = OP_ANDI;
            3:       op = OP_ORI;
            4:       op = OP_XORI;
            default: op = OP_LUI;
          endcase
          imem_img[i] = {op, 5'($urandom), 5'($urandom % 31), 16'($urandom)};
        end
        11: imem_img[i] = {OP_LW, 5'd0, 5'($urandom % 31), mem_offset()};
        12: imem_img[i] = {OP_SW, 5'd0, 5'($urandom), mem_offset()};
        13, 14: begin  // Low registers so beq is taken often enough
          op = ($urandom % 2) ? OP_BEQ : OP_BNE;
          imem_img[i] = {op, 5'($urandom % 4), 5'($urandom % 4), 16'(tgt - i - 1)};
        end
        default: imem_img[i] = ($urandom % 2) ? {OP_JAL, 26'(SUB_IDX)} : {OP_J, 26'(tgt)};
      endcase
    end
    imem_img[SUB_IDX - 1] = {OP_J, 26'd0};  // Main body loops
    imem_img[SUB_IDX]     = alu_rtype(0);
    imem_img[SUB_IDX + 1] = {OP_RTYPE, REG_RA, 15'd0, FN_JR};
    imem_img[SUB_IDX + 2] = {OP_J, 26'd0};
  endtask

  ////////////////////////////////////////////////////////////
  // Reset, load port and run control
  ////////////////////////////////////////////////////////////
  task automatic apply_reset;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int r = 0; r < 32; r++) m_regs[r] = '0;
    m_pc  = '0;
    m_led = '0;
    check_word("led_o after reset", 32'd0, {8'h00, led});
  endtask

  task automatic load_word(input logic [UPG_AW-1:0] adr, input logic [31:0] dat);
    upg_wen = 1'b1;
    upg_adr = adr;
    upg_dat = dat;
    @(posedge clk);
    #1 upg_wen = 1'b0;
  endtask

  task automatic start_run;
    upg_done = 1'b1;  // One-cycle pulse
    @(posedge clk);
    #1 upg_done = 1'b0;
  endtask

  // One instruction through the model, checked against the DUT
  task automatic run_cycle;
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [31:0] res;
    logic [31:0] wval;
    logic [4:0]  wreg;
    bit          has_res;
    @(negedge clk);  // Combinational path settled
    pc      = m_pc;
    ins     = imem_img[pc[11:2]];
    a       = m_regs[ins[25:21]];
    b       = m_regs[ins[20:16]];
    imm     = {{16{ins[15]}}, ins[15:0]};
    pc4     = pc + 32'd4;
    res     = '0;
    has_res = 1'b1;
    wreg    = ins[20:16];
    m_pc    = pc4;
    case (ins[31:26])
      OP_RTYPE: begin
        wreg = ins[15:11];
        case (ins[5:0])
          FN_ADDU: res = a + b;
          FN_SUBU: res = a - b;
          FN_AND:  res = a & b;
          FN_OR:   res = a | b;
          FN_XOR:  res = a ^ b;
          FN_NOR:  res = ~(a | b);
          FN_SLT:  res = {31'd0, $signed(a) < $signed(b)};
          FN_SLL:  res = b << ins[10:6];
          FN_SRL:  res = b >> ins[10:6];
          FN_SRA:  res = $signed(b) >>> ins[10:6];
          default: begin  // jr
            has_res = 1'b0;
            wreg    = 5'd0;
            m_pc    = a;
          end
        endcase
      end
      OP_ADDIU:       res = a + imm;
      OP_SLTI:        res = {31'd0, $signed(a) < $signed(imm)};
      OP_ANDI:        res = a & {16'h0000, ins[15:0]};
      OP_ORI:         res = a | {16'h0000, ins[15:0]};
      OP_XORI:        res = a ^ {16'h0000, ins[15:0]};
      OP_LUI:         res = {ins[15:0], 16'h0000};
      OP_LW, OP_SW:   res = a + imm;  // Effective address
      OP_BEQ, OP_BNE: begin
        res  = a - b;
        wreg = 5'd0;
        if ((a == b) == (ins[31:26] == OP_BEQ)) m_pc = pc4 + {imm[29:0], 2'b00};
      end
      default: begin  // j and jal
        has_res = 1'b0;
        wreg    = (ins[31:26] == OP_JAL) ? REG_RA : 5'd0;
        m_pc    = {pc4[31:28], ins[25:0], 2'b00};
      end
    endcase
    wval = (ins[31:26] == OP_JAL) ? pc4 : res;
    if (ins[31:26] == OP_LW) begin
      if (res == IO_SWITCH_ADDR) wval = {8'h00, sw_in};
      else if (res == IO_LED_ADDR) wval = {8'h00, m_led};  // LED readback
      else wval = m_dmem[res[11:2]];
    end
    if (ins[31:26] == OP_SW) begin
      wreg = 5'd0;
      if (res == IO_LED_ADDR) m_led = b[IO_W-1:0];
      else if (res != IO_SWITCH_ADDR) m_dmem[res[11:2]] = b;  // Switch port is read-only
    end
    if (has_res) check_word($sformatf("debug_o pc=%h", pc), res, debug);
    if (wreg != 5'd0) m_regs[wreg] = wval;
    @(posedge clk);
    #1 check_word($sformatf("led_o pc=%h", pc), {8'h00, m_led}, {8'h00, led});
    sw_in = $urandom;  // New switch value every cycle
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed     = $urandom(seed);
    rst_n    = 1'b0;
    sw_in    = $urandom;
    upg_wen  = 1'b0;
    upg_adr  = '0;
    upg_dat  = '0;
    upg_done = 1'b0;
    for (int k = 0; k < MEM_WORDS; k++) begin
      imem_img[k] = '0;  // Unloaded words are nops
      m_dmem[k]   = '0;
    end
    gen_program();
    apply_reset();
    for (int k = 0; k < PROG_LEN; k++) load_word({1'b0, 14'(k)}, imem_img[k]);  // Bit 14 low, imem
    for (int k = 0; k < DATA_LEN; k++) begin
      m_dmem[k] = $urandom;
      load_word({1'b1, 14'(k)}, m_dmem[k]);
    end
    start_run();
    repeat (300) run_cycle();
    while (imem_img[m_pc[11:2]][31:26] == OP_SW) run_cycle();  // No store on the reset edge
    apply_reset();
    for (int k = 0; k < 8; k++) begin  // Refresh a few data words
      seed = $urandom % DATA_LEN;
      m_dmem[seed] = $urandom;
      load_word({1'b1, 14'(seed)}, m_dmem[seed]);
    end
    start_run();
    repeat (100) run_cycle();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
logic/isa_pkg.sv
logic/core_pkg.sv
logic/inst_fetch.sv
logic/main_control.sv
logic/reg_decode.sv
logic/alu_exec.sv
logic/dmem_io.sv
logic/cpu_top.sv
sim/tb_cpu_top.sv
